// ==== rtl/ooo_pkg.sv ====
package ooo_pkg;

  localparam int ARCH_REGS = 16;
  localparam int ROB_DEPTH = 8;
  localparam int XLEN      = 32;

  typedef logic [$clog2(ARCH_REGS)-1:0] arch_id_t;
  typedef logic [$clog2(ROB_DEPTH)-1:0] rob_id_t;

  // alu opcodes, imm forms take src2 from the packet
  typedef enum logic [3:0] {
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_SLL,
    OP_SRL,
    OP_ADDI,
    OP_LI
  } alu_op_e;

  // instruction as it arrives at dispatch
  typedef struct packed {
    alu_op_e         op;
    arch_id_t        rd;
    arch_id_t        rs1;
    arch_id_t        rs2;
    logic [XLEN-1:0] imm;
  } dispatch_pkt_t;

  typedef struct packed {
    logic            ready;
    rob_id_t         tag;   // producer while not ready
    logic [XLEN-1:0] value;
  } operand_t;

  typedef struct packed {
    alu_op_e  op;
    rob_id_t  rob_id;
    operand_t src1;
    operand_t src2;
  } iq_entry_t;

  // result broadcast
  typedef struct packed {
    logic            valid;
    rob_id_t         rob_id;
    logic [XLEN-1:0] data;
  } cdb_t;

  typedef struct packed {
    arch_id_t        rd;
    rob_id_t         rob_id;
    logic [XLEN-1:0] data;
  } retire_t;

endpackage

// ==== rtl/rename_stage.sv ====
`timescale 1ns/1ps

module rename_stage (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                pkg_valid_i,
  output logic                                pkg_ready_o,
  input  ooo_pkg::dispatch_pkt_t              pkg_i,
  input  logic                                rob_ready_i,
  input  ooo_pkg::rob_id_t                    alloc_id_i,
  output logic                                alloc_valid_o,
  output ooo_pkg::arch_id_t                   alloc_rd_o,
  output ooo_pkg::rob_id_t [1:0]              rob_rid_o,
  input  logic [1:0]                          rob_done_i,
  input  logic [1:0][ooo_pkg::XLEN-1:0]       rob_data_i,
  input  logic                                iq_ready_i,
  output logic                                iq_valid_o,
  output ooo_pkg::iq_entry_t                  iq_entry_o,
  input  ooo_pkg::cdb_t                       cdb_i,
  input  logic                                retire_fire_i,
  input  ooo_pkg::retire_t                    retire_i
);

  logic [ooo_pkg::XLEN-1:0] arf [ooo_pkg::ARCH_REGS];
  logic [ooo_pkg::ARCH_REGS-1:0] map_valid;
  ooo_pkg::rob_id_t map_tag [ooo_pkg::ARCH_REGS];

  logic accept;
  ooo_pkg::arch_id_t [1:0] src_reg;
  ooo_pkg::operand_t [1:0] src_opnd;
  ooo_pkg::operand_t imm_opnd;

  // both downstream stages must have room
  assign pkg_ready_o = rob_ready_i & iq_ready_i;
  assign accept      = pkg_valid_i & pkg_ready_o;

  assign alloc_valid_o = accept;
  assign alloc_rd_o    = pkg_i.rd;
  assign iq_valid_o    = accept;

  assign src_reg[0] = pkg_i.rs1;
  assign src_reg[1] = pkg_i.rs2;

  assign imm_opnd.ready = 1'b1;
  assign imm_opnd.tag   = '0;
  assign imm_opnd.value = pkg_i.imm;

  always_comb begin
    for (int i = 0; i < 2; i++) begin
      rob_rid_o[i] = map_tag[src_reg[i]];
    end
  end

  // r0, then arf, then finished rob entry, then cdb, else wait on tag
  always_comb begin
    for (int i = 0; i < 2; i++) begin
      src_opnd[i].ready = 1'b0;
      src_opnd[i].tag   = map_tag[src_reg[i]];
      src_opnd[i].value = '0;
      if (src_reg[i] == '0) begin
        src_opnd[i].ready = 1'b1;
      end else if (!map_valid[src_reg[i]]) begin
        src_opnd[i].ready = 1'b1;
        src_opnd[i].value = arf[src_reg[i]];
      end else if (rob_done_i[i]) begin
        src_opnd[i].ready = 1'b1;
        src_opnd[i].value = rob_data_i[i];
      end else if (cdb_i.valid && cdb_i.rob_id == map_tag[src_reg[i]]) begin
        src_opnd[i].ready = 1'b1;  // result broadcast this cycle
        src_opnd[i].value = cdb_i.data;
      end
    end
  end

  always_comb begin
    iq_entry_o.op     = pkg_i.op;
    iq_entry_o.rob_id = alloc_id_i;
    iq_entry_o.src1   = src_opnd[0];
    iq_entry_o.src2   = src_opnd[1];
    case (pkg_i.op)
      ooo_pkg::OP_ADDI: begin
        iq_entry_o.src2 = imm_opnd;
      end
      ooo_pkg::OP_LI: begin
        iq_entry_o.src1.ready = 1'b1;  // rs1 ignored
        iq_entry_o.src1.value = '0;
        iq_entry_o.src2       = imm_opnd;
      end
      default: ;
    endcase
  end

  // architectural state, written at retire
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < ooo_pkg::ARCH_REGS; i++) begin
        arf[i] <= '0;
      end
    end else if (retire_fire_i && retire_i.rd != '0) begin
      arf[retire_i.rd] <= retire_i.data;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      map_valid <= '0;
      for (int i = 0; i < ooo_pkg::ARCH_REGS; i++) begin
        map_tag[i] <= '0;
      end
    end else begin
      // only drop the mapping if no younger writer took it over
      if (retire_fire_i && map_valid[retire_i.rd] && map_tag[retire_i.rd] == retire_i.rob_id) begin
        map_valid[retire_i.rd] <= 1'b0;
      end
      if (accept && pkg_i.rd != '0) begin
        map_valid[pkg_i.rd] <= 1'b1;
        map_tag[pkg_i.rd]   <= alloc_id_i;
      end
    end
  end

endmodule

// ==== rtl/reorder_buffer.sv ====
`timescale 1ns/1ps

module reorder_buffer (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          alloc_valid_i,
  input  ooo_pkg::arch_id_t             alloc_rd_i,
  output ooo_pkg::rob_id_t              alloc_id_o,
  output logic                          rob_ready_o,
  input  ooo_pkg::rob_id_t [1:0]        rob_rid_i,
  output logic [1:0]                    rob_done_o,
  output logic [1:0][ooo_pkg::XLEN-1:0] rob_data_o,
  input  ooo_pkg::cdb_t                 cdb_i,
  output logic                          retire_valid_o,
  input  logic                          retire_ready_i,
  output ooo_pkg::retire_t              retire_o
);

  localparam int CNT_W = $clog2(ooo_pkg::ROB_DEPTH + 1);

  ooo_pkg::arch_id_t        rd_q   [ooo_pkg::ROB_DEPTH];
  logic [ooo_pkg::XLEN-1:0] data_q [ooo_pkg::ROB_DEPTH];
  logic [ooo_pkg::ROB_DEPTH-1:0] done_q;

  ooo_pkg::rob_id_t head_q;
  ooo_pkg::rob_id_t tail_q;
  logic [CNT_W-1:0] count_q;
  logic retire_fire;

  assign alloc_id_o  = tail_q;
  assign rob_ready_o = (count_q != CNT_W'(ooo_pkg::ROB_DEPTH));

  // operand read ports for rename
  always_comb begin
    for (int i = 0; i < 2; i++) begin
      rob_done_o[i] = done_q[rob_rid_i[i]];
      rob_data_o[i] = data_q[rob_rid_i[i]];
    end
  end

  // head stays put until accepted, so the port holds steady
  assign retire_valid_o  = (count_q != '0) && done_q[head_q];
  assign retire_o.rd     = rd_q[head_q];
  assign retire_o.rob_id = head_q;
  assign retire_o.data   = data_q[head_q];
  assign retire_fire     = retire_valid_o & retire_ready_i;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end else begin
      if (alloc_valid_i) begin
        tail_q <= tail_q + 1'b1;  // wraps with the id width
      end
      if (retire_fire) begin
        head_q <= head_q + 1'b1;
      end
      case ({alloc_valid_i, retire_fire})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      done_q <= '0;
    end else begin
      if (alloc_valid_i) begin
        done_q[tail_q] <= 1'b0;
      end
      if (cdb_i.valid) begin
        done_q[cdb_i.rob_id] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (alloc_valid_i) begin
      rd_q[tail_q] <= alloc_rd_i;
    end
    if (cdb_i.valid) begin
      data_q[cdb_i.rob_id] <= cdb_i.data;
    end
  end

endmodule

// ==== rtl/alu_issue_queue.sv ====
`timescale 1ns/1ps

module alu_issue_queue #(
  parameter int IQ_DEPTH = 4
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               iq_valid_i,
  input  ooo_pkg::iq_entry_t iq_entry_i,
  output logic               iq_ready_o,
  output ooo_pkg::cdb_t      cdb_o
);

  localparam int IDX_W = (IQ_DEPTH > 1) ? $clog2(IQ_DEPTH) : 1;

  ooo_pkg::iq_entry_t slots [IQ_DEPTH];
  logic [IQ_DEPTH-1:0] slot_valid;

  logic free_found;
  logic [IDX_W-1:0] free_idx;
  logic issue_valid;
  logic [IDX_W-1:0] issue_idx;
  ooo_pkg::iq_entry_t issue_entry;
  logic [ooo_pkg::XLEN-1:0] alu_a;
  logic [ooo_pkg::XLEN-1:0] alu_b;
  logic [ooo_pkg::XLEN-1:0] alu_res;

  // capture a broadcast result into a waiting operand
  function automatic ooo_pkg::operand_t wake(input ooo_pkg::operand_t opnd,
                                             input ooo_pkg::cdb_t cdb);
    ooo_pkg::operand_t res;
    res = opnd;
    if (!opnd.ready && cdb.valid && cdb.rob_id == opnd.tag) begin
      res.ready = 1'b1;
      res.value = cdb.data;
    end
    return res;
  endfunction

  // lowest free slot
  always_comb begin
    free_found = 1'b0;
    free_idx   = '0;
    for (int i = IQ_DEPTH - 1; i >= 0; i--) begin
      if (!slot_valid[i]) begin
        free_found = 1'b1;
        free_idx   = IDX_W'(i);
      end
    end
  end

  assign iq_ready_o = free_found;

  // lowest slot with both operands in hand
  always_comb begin
    issue_valid = 1'b0;
    issue_idx   = '0;
    for (int i = IQ_DEPTH - 1; i >= 0; i--) begin
      if (slot_valid[i] && slots[i].src1.ready && slots[i].src2.ready) begin
        issue_valid = 1'b1;
        issue_idx   = IDX_W'(i);
      end
    end
  end

  assign issue_entry = slots[issue_idx];
  assign alu_a       = issue_entry.src1.value;
  assign alu_b       = issue_entry.src2.value;

  always_comb begin
    case (issue_entry.op)
      ooo_pkg::OP_ADD:  alu_res = alu_a + alu_b;
      ooo_pkg::OP_SUB:  alu_res = alu_a - alu_b;
      ooo_pkg::OP_AND:  alu_res = alu_a & alu_b;
      ooo_pkg::OP_OR:   alu_res = alu_a | alu_b;
      ooo_pkg::OP_XOR:  alu_res = alu_a ^ alu_b;
      ooo_pkg::OP_SLL:  alu_res = alu_a << alu_b[4:0];
      ooo_pkg::OP_SRL:  alu_res = alu_a >> alu_b[4:0];
      ooo_pkg::OP_ADDI: alu_res = alu_a + alu_b;  // imm already in src2
      ooo_pkg::OP_LI:   alu_res = alu_b;
      default:          alu_res = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      slot_valid <= '0;
    end else begin
      if (issue_valid) begin
        slot_valid[issue_idx] <= 1'b0;
      end
      if (iq_valid_i) begin
        slot_valid[free_idx] <= 1'b1;
      end
    end
  end

  // wakeup on our own cdb, new entry overrides its slot
  always_ff @(posedge clk) begin
    for (int i = 0; i < IQ_DEPTH; i++) begin
      slots[i].src1 <= wake(slots[i].src1, cdb_o);
      slots[i].src2 <= wake(slots[i].src2, cdb_o);
    end
    if (iq_valid_i) begin
      slots[free_idx] <= iq_entry_i;
    end
  end

  // result register, drives the cdb one cycle after issue
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cdb_o.valid <= 1'b0;
    end else begin
      cdb_o.valid <= issue_valid;
      if (issue_valid) begin
        cdb_o.rob_id <= issue_entry.rob_id;
        cdb_o.data   <= alu_res;
      end
    end
  end

endmodule

// ==== rtl/ooo_backend.sv ====
`timescale 1ns/1ps

module ooo_backend #(
  parameter int IQ_DEPTH = 4
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   pkg_valid_i,
  output logic                   pkg_ready_o,
  input  ooo_pkg::dispatch_pkt_t pkg_i,
  output logic                   retire_valid_o,
  input  logic                   retire_ready_i,
  output ooo_pkg::retire_t       retire_o
);

  // rename to rob
  logic                          alloc_valid;
  ooo_pkg::arch_id_t             alloc_rd;
  ooo_pkg::rob_id_t              alloc_id;
  logic                          rob_ready;
  ooo_pkg::rob_id_t [1:0]        rob_rid;
  logic [1:0]                    rob_done;
  logic [1:0][ooo_pkg::XLEN-1:0] rob_data;

  // rename to issue queue
  logic                          iq_valid;
  ooo_pkg::iq_entry_t            iq_entry;
  logic                          iq_ready;

  ooo_pkg::cdb_t                 cdb;
  wire                           retire_fire = retire_valid_o & retire_ready_i;

  rename_stage u_rename_stage (
    .clk           (clk),
    .rst_n         (rst_n),
    .pkg_valid_i   (pkg_valid_i),
    .pkg_ready_o   (pkg_ready_o),
    .pkg_i         (pkg_i),
    .rob_ready_i   (rob_ready),
    .alloc_id_i    (alloc_id),
    .alloc_valid_o (alloc_valid),
    .alloc_rd_o    (alloc_rd),
    .rob_rid_o     (rob_rid),
    .rob_done_i    (rob_done),
    .rob_data_i    (rob_data),
    .iq_ready_i    (iq_ready),
    .iq_valid_o    (iq_valid),
    .iq_entry_o    (iq_entry),
    .cdb_i         (cdb),
    .retire_fire_i (retire_fire),
    .retire_i      (retire_o)
  );

  reorder_buffer u_reorder_buffer (
    .clk            (clk),
    .rst_n          (rst_n),
    .alloc_valid_i  (alloc_valid),
    .alloc_rd_i     (alloc_rd),
    .alloc_id_o     (alloc_id),
    .rob_ready_o    (rob_ready),
    .rob_rid_i      (rob_rid),
    .rob_done_o     (rob_done),
    .rob_data_o     (rob_data),
    .cdb_i          (cdb),
    .retire_valid_o (retire_valid_o),
    .retire_ready_i (retire_ready_i),
    .retire_o       (retire_o)
  );

  alu_issue_queue #(
    .IQ_DEPTH (IQ_DEPTH)
  ) u_alu_issue_queue (
    .clk        (clk),
    .rst_n      (rst_n),
    .iq_valid_i (iq_valid),
    .iq_entry_i (iq_entry),
    .iq_ready_o (iq_ready),
    .cdb_o      (cdb)
  );

endmodule

// ==== tb/ooo_backend_tb.sv ====
`timescale 1ns/1ps

module ooo_backend_tb;

  localparam int N_RANDOM    = 300;
  localparam int N_STALL     = 200;
  localparam int N_CHAINS    = 38;
  localparam int N_R0        = 6;
  localparam int TOTAL_INSTR = 1 + N_RANDOM + N_CHAINS + N_R0 + N_STALL;
  localparam int MAX_CYCLES  = 40 * TOTAL_INSTR;

  logic                   clk;
  logic                   rst_n;
  logic                   pkg_valid_i;
  logic                   pkg_ready_o;
  ooo_pkg::dispatch_pkt_t pkg_i;
  logic                   retire_valid_o;
  logic                   retire_ready_i;
  ooo_pkg::retire_t       retire_o;

  logic [ooo_pkg::XLEN-1:0] model_regs [ooo_pkg::ARCH_REGS];
  ooo_pkg::retire_t model_q [$];
  ooo_pkg::retire_t exp_head;
  ooo_pkg::retire_t exp_new;
  ooo_pkg::rob_id_t exp_rid;
  int    pending = 0;   // accepted, not yet retired
  int    err_cnt = 0;
  int    test_cnt = 0;
  int    test_err_base = 0;
  int    cycle_cnt = 0;
  string test_name = "reset";
  logic  stream_done;

  ooo_backend #(
    .IQ_DEPTH (4)
  ) u_ooo_backend (
    .clk            (clk),
    .rst_n          (rst_n),
    .pkg_valid_i    (pkg_valid_i),
    .pkg_ready_o    (pkg_ready_o),
    .pkg_i          (pkg_i),
    .retire_valid_o (retire_valid_o),
    .retire_ready_i (retire_ready_i),
    .retire_o       (retire_o)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // program-order result of one instruction on the model registers
  function automatic logic [ooo_pkg::XLEN-1:0] ref_result(input ooo_pkg::dispatch_pkt_t p);
    logic [ooo_pkg::XLEN-1:0] a;
    logic [ooo_pkg::XLEN-1:0] b;
    a = model_regs[p.rs1];
    b = model_regs[p.rs2];
    case (p.op)
      ooo_pkg::OP_ADD:  return a + b;
      ooo_pkg::OP_SUB:  return a - b;
      ooo_pkg::OP_AND:  return a & b;
      ooo_pkg::OP_OR:   return a | b;
      ooo_pkg::OP_XOR:  return a ^ b;
      ooo_pkg::OP_SLL:  return a << b[4:0];
      ooo_pkg::OP_SRL:  return a >> b[4:0];
      ooo_pkg::OP_ADDI: return a + p.imm;
      ooo_pkg::OP_LI:   return p.imm;
      default:          return '0;
    endcase
  endfunction

  always @(posedge clk) begin
    if (!rst_n) begin
      model_q.delete();
      exp_rid = '0;
      for (int i = 0; i < ooo_pkg::ARCH_REGS; i++) begin
        model_regs[i] = '0;
      end
    end else begin
      if (retire_valid_o && retire_ready_i && model_q.size() != 0) begin
        void'(model_q.pop_front());
        exp_rid = exp_rid + 1'b1;  // wraps with the id width
      end
      if (pkg_valid_i && pkg_ready_o) begin
        exp_new.rd     = pkg_i.rd;
        exp_new.rob_id = '0;
        exp_new.data   = ref_result(pkg_i);
        if (pkg_i.rd != '0) model_regs[pkg_i.rd] = exp_new.data;
        model_q.push_back(exp_new);
      end
    end
    pending  = model_q.size();
    exp_head = (pending != 0) ? model_q[0] : '0;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("TEST FAILED");
      $finish;
    end
  end

  // sampled on the falling edge, where every signal is settled
  a_reset_state: assert property (@(negedge clk) $rose(rst_n) |-> !retire_valid_o && pkg_ready_o)
    else begin
      err_cnt++;
      $display("%s: after reset retire_valid_o is high or pkg_ready_o is low", test_name);
    end

  a_retire_expected: assert property (@(negedge clk) disable iff (!rst_n)
      retire_valid_o && retire_ready_i |-> pending != 0)
    else begin
      err_cnt++;
      $display("%s: retirement with no instruction outstanding", test_name);
    end

  a_retire_value: assert property (@(negedge clk) disable iff (!rst_n)
      retire_valid_o && retire_ready_i && pending != 0 |->
      retire_o.rd == exp_head.rd && retire_o.data == exp_head.data)
    else begin
      err_cnt++;
      $display("MISMATCH %s expected rd=%0d data=%h actual rd=%0d data=%h", test_name,
               exp_head.rd, exp_head.data, retire_o.rd, retire_o.data);
    end

  a_retire_id: assert property (@(negedge clk) disable iff (!rst_n)
      retire_valid_o && retire_ready_i |-> retire_o.rob_id == exp_rid)
    else begin
      err_cnt++;
      $display("MISMATCH %s expected rob_id=%0d actual rob_id=%0d", test_name,
               exp_rid, retire_o.rob_id);
    end

  a_retire_hold: assert property (@(negedge clk) disable iff (!rst_n)
      retire_valid_o && !retire_ready_i |=> retire_valid_o && $stable(retire_o))
    else begin
      err_cnt++;
      $display("%s: retire port changed or dropped while stalled", test_name);
    end

  a_occupancy: assert property (@(negedge clk) disable iff (!rst_n)
      pending <= ooo_pkg::ROB_DEPTH)
    else begin
      err_cnt++;
      $display("%s: more than %0d instructions in flight", test_name, ooo_pkg::ROB_DEPTH);
    end

  function automatic ooo_pkg::dispatch_pkt_t make_pkt(input ooo_pkg::alu_op_e op,
      input ooo_pkg::arch_id_t rd, input ooo_pkg::arch_id_t rs1,
      input ooo_pkg::arch_id_t rs2, input logic [ooo_pkg::XLEN-1:0] imm);
    ooo_pkg::dispatch_pkt_t p;
    p.op  = op;
    p.rd  = rd;
    p.rs1 = rs1;
    p.rs2 = rs2;
    p.imm = imm;
    return p;
  endfunction

  // called on a rising edge, returns on the edge of acceptance
  task automatic send_instr(input ooo_pkg::dispatch_pkt_t p);
    pkg_valid_i <= 1'b1;
    pkg_i       <= p;
    @(posedge clk);
    while (!pkg_ready_o) @(posedge clk);
    pkg_valid_i <= 1'b0;
  endtask

  task automatic send_random(input int n);
    ooo_pkg::dispatch_pkt_t p;
    for (int i = 0; i < n; i++) begin
      p.op  = ooo_pkg::alu_op_e'($urandom_range(8));
      p.rd  = ooo_pkg::arch_id_t'($urandom_range(7));  // few regs, many hazards
      p.rs1 = ooo_pkg::arch_id_t'($urandom_range(7));
      p.rs2 = ooo_pkg::arch_id_t'($urandom_range(7));
      p.imm = $urandom;
      send_instr(p);
      if ($urandom_range(7) == 0) @(posedge clk);
    end
  endtask

  task automatic run_chain(input ooo_pkg::alu_op_e op, input ooo_pkg::arch_id_t rd,
                           input ooo_pkg::arch_id_t rs2);
    send_instr(make_pkt(ooo_pkg::OP_LI, rd, '0, '0, $urandom));
    repeat (8) begin
      send_instr(make_pkt(op, rd, rd, rs2, $urandom_range(255)));
    end
  endtask

  task automatic toggle_retire_ready();
    int hold;
    while (!stream_done) begin
      hold = $urandom_range(12, 1);
      retire_ready_i <= ($urandom_range(2) == 0);  // stalled about two thirds
      repeat (hold) @(posedge clk);
    end
    retire_ready_i <= 1'b1;
  endtask

  task automatic end_test();
    do @(negedge clk); while (pending != 0);
    repeat (2) @(negedge clk);
    @(posedge clk);
    test_cnt++;
    $display("test %s finished with %0d errors", test_name, err_cnt - test_err_base);
    test_err_base = err_cnt;
  endtask

  initial begin
    void'($urandom(32'h180c));
    rst_n          = 1'b0;
    pkg_valid_i    = 1'b0;
    pkg_i          = '0;
    retire_ready_i = 1'b1;
    stream_done    = 1'b0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);

    test_name = "reset_first_add";
    send_instr(make_pkt(ooo_pkg::OP_ADD, 4'd1, 4'd1, 4'd2, '0));
    end_test();

    test_name = "random_stream";
    send_random(N_RANDOM);
    end_test();

    test_name = "dependent_chains";
    send_instr(make_pkt(ooo_pkg::OP_LI, 4'd5, '0, '0, 32'h11));
    send_instr(make_pkt(ooo_pkg::OP_LI, 4'd9, '0, '0, 32'd3));  // shift amount
    run_chain(ooo_pkg::OP_ADDI, 4'd3, '0);
    run_chain(ooo_pkg::OP_SUB, 4'd4, 4'd5);
    run_chain(ooo_pkg::OP_SLL, 4'd6, 4'd9);
    run_chain(ooo_pkg::OP_XOR, 4'd7, 4'd4);
    end_test();

    test_name = "r0_writes";
    send_instr(make_pkt(ooo_pkg::OP_LI, 4'd0, '0, '0, 32'h1234));
    send_instr(make_pkt(ooo_pkg::OP_ADDI, 4'd0, 4'd0, '0, 32'h55));
    send_instr(make_pkt(ooo_pkg::OP_ADD, 4'd10, 4'd0, 4'd0, '0));
    send_instr(make_pkt(ooo_pkg::OP_ADDI, 4'd11, 4'd0, '0, 32'h7));
    send_instr(make_pkt(ooo_pkg::OP_OR, 4'd0, 4'd11, 4'd11, '0));
    send_instr(make_pkt(ooo_pkg::OP_XOR, 4'd12, 4'd0, 4'd11, '0));
    end_test();

    test_name = "back_pressure";
    fork
      begin
        send_random(N_STALL);
        stream_done <= 1'b1;
      end
      toggle_retire_ready();
    join
    end_test();

    $display("summary: %0d tests run, %0d errors", test_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== ooo_backend.f ====
rtl/ooo_pkg.sv
rtl/rename_stage.sv
rtl/reorder_buffer.sv
rtl/alu_issue_queue.sv
rtl/ooo_backend.sv
tb/ooo_backend_tb.sv
